// ==== Makefile ====
SIM       = verilator
TOP       = spi_xip_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
RUN_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
BIN       = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	-./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/spi_bus_bridge.sv ====
`default_nettype none
`include "spi_macros.svh"

module spi_bus_bridge (
  input  wire         clock,
  input  wire         reset,
  input  wire  [31:0] paddr_i,
  input  wire         psel_i,
  input  wire         penable_i,
  input  wire         pwrite_i,
  input  wire  [31:0] pwdata_i,
  input  wire  [3:0]  pstrb_i,
  output logic        pready_o,
  output logic [31:0] prdata_o,
  output logic        pslverr_o,
  output logic        xip_req_o,
  output logic [23:0] xip_addr_o,
  input  wire         xip_done_i,
  input  wire  [31:0] xip_data_i,
  spi_reg_if.slave    seq_bus,
  spi_reg_if.master   reg_bus
);
  spi_pkg::bridge_state_e state_q;
  logic        err_q;
  logic        xip_req_q;
  logic [31:0] prdata_q;
  logic        in_spi;
  logic        in_flash;
  logic        setup;
  logic        access;

  // Window decode on the held APB address
  assign in_spi   = (paddr_i >= `SPI_BASE) && (paddr_i <= `SPI_END);
  assign in_flash = (paddr_i >= `FLASH_BASE) && (paddr_i <= `FLASH_END);
  assign setup    = psel_i && !penable_i;
  assign access   = psel_i && penable_i;

  assign pready_o   = (state_q == spi_pkg::BR_RESP);
  assign pslverr_o  = (state_q == spi_pkg::BR_RESP) && err_q;
  assign prdata_o   = prdata_q;
  assign xip_req_o  = xip_req_q;
  // Low 24 bits address the flash directly
  assign xip_addr_o = paddr_i[23:0];

  // Register bus owner: sequencer during XIP, APB otherwise
  always_comb begin
    if (state_q == spi_pkg::BR_XIP) begin
      reg_bus.adr  = seq_bus.adr;
      reg_bus.wdat = seq_bus.wdat;
      reg_bus.sel  = seq_bus.sel;
      reg_bus.we   = seq_bus.we;
      reg_bus.stb  = seq_bus.stb;
    end else begin
      reg_bus.adr  = paddr_i[4:0];
      reg_bus.wdat = pwdata_i;
      reg_bus.sel  = pstrb_i;
      reg_bus.we   = pwrite_i;
      reg_bus.stb  = (state_q == spi_pkg::BR_REG);
    end
  end

  // Sequencer only sees its own acknowledges
  assign seq_bus.ack  = (state_q == spi_pkg::BR_XIP) && reg_bus.ack;
  assign seq_bus.rdat = reg_bus.rdat;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q   <= spi_pkg::BR_IDLE;
      err_q     <= 1'b0;
      xip_req_q <= 1'b0;
    end else begin
      xip_req_q <= 1'b0;
      case (state_q)
        spi_pkg::BR_IDLE: begin
          // Good accesses start in setup, bad ones answer in access
          if (setup && in_spi) begin
            state_q <= spi_pkg::BR_REG;
          end else if (setup && in_flash && !pwrite_i) begin
            state_q   <= spi_pkg::BR_XIP;
            xip_req_q <= 1'b1;
          end else if (access) begin
            state_q <= spi_pkg::BR_RESP;
            err_q   <= 1'b1;
          end
        end
        spi_pkg::BR_REG: begin
          if (reg_bus.ack) begin
            state_q <= spi_pkg::BR_RESP;
          end
        end
        spi_pkg::BR_XIP: begin
          if (xip_done_i) begin
            state_q <= spi_pkg::BR_RESP;
          end
        end
        default: begin
          state_q <= spi_pkg::BR_IDLE;
          err_q   <= 1'b0;
        end
      endcase
    end
  end

  // Read data captured with the completing event
  always_ff @(posedge clock) begin
    if (state_q == spi_pkg::BR_REG && reg_bus.ack) begin
      prdata_q <= reg_bus.rdat;
    end else if (state_q == spi_pkg::BR_XIP && xip_done_i) begin
      prdata_q <= xip_data_i;
    end else if (state_q == spi_pkg::BR_IDLE && access) begin
      prdata_q <= 32'd0;
    end
  end
endmodule

`default_nettype wire

// ==== hw/spi_macros.svh ====
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Register window of the SPI master
`define SPI_BASE 32'h1000_1000
`define SPI_END 32'h1000_1FFF

// Execute-in-place window, maps onto the 24-bit flash address
`define FLASH_BASE 32'h3000_0000
`define FLASH_END 32'h3FFF_FFFF

// Slave select lines on the pads
`define SS_NUM 8

// Flash read opcode and XIP clock divider
`define FLASH_READ_CMD 8'h03
`define XIP_DIVIDER 16'd1

// Bit positions in CTRL
`define CTRL_GO_BSY 8
`define CTRL_IE 12

`endif

// ==== hw/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

  // Register offsets on the internal register bus
  // data registers share RX and TX at the same offset
  typedef enum logic [4:0] {
    REG_RXTX0   = 5'h00,
    REG_RXTX1   = 5'h04,
    REG_CTRL    = 5'h10,
    REG_DIVIDER = 5'h14,
    REG_SS      = 5'h18
  } spi_reg_e;

  // XIP read sequence, one bus cycle per step
  typedef enum logic [3:0] {
    XIP_IDLE,
    XIP_TX_HI,
    XIP_TX_LO,
    XIP_DIV,
    XIP_SS,
    XIP_GO,
    XIP_POLL,
    XIP_READ,
    XIP_DONE
  } xip_state_e;

  // APB bridge states
  typedef enum logic [1:0] {
    BR_IDLE,
    BR_REG,
    BR_XIP,
    BR_RESP
  } bridge_state_e;

endpackage

`default_nettype wire

// ==== hw/spi_reg_if.sv ====
`default_nettype none

// Internal register bus, strobe held until a one-cycle acknowledge
interface spi_reg_if;
  logic [4:0]  adr;
  logic [31:0] wdat;
  logic [31:0] rdat;
  logic [3:0]  sel;
  logic        we;
  logic        stb;
  logic        ack;

  // Requesting side
  modport master (
    output adr, wdat, sel, we, stb,
    input  rdat, ack
  );

  // Register file side
  modport slave (
    input  adr, wdat, sel, we, stb,
    output rdat, ack
  );
endinterface

`default_nettype wire

// ==== hw/spi_regs.sv ====
`default_nettype none
`include "spi_macros.svh"

module spi_regs (
  input  wire                 clock,
  input  wire                 reset,
  spi_reg_if.slave            bus,
  output logic                spi_sck_o,
  output logic [`SS_NUM-1:0]  spi_ss_o,
  output logic                spi_mosi_o,
  input  wire                 spi_miso_i,
  output logic                irq_o
);
  logic [63:0]        data_q;
  logic [6:0]         char_len_q;
  logic               ie_q;
  logic [15:0]        divider_q;
  logic [`SS_NUM-1:0] ss_q;
  logic               ack_q;
  logic [31:0]        rdat_q;
  logic               irq_q;
  logic               busy;
  logic               busy_d;
  logic               done;
  logic               access;
  logic               wr_en;
  logic               start;
  logic [31:0]        reg_word;
  logic [31:0]        wr_word;
  logic [63:0]        rx_data;

  // Byte lanes from the bus replace the current word
  function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
                                              input logic [31:0] wdat,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    int i;
    res = cur;
    for (i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = wdat[8*i +: 8];
      end
    end
    return res;
  endfunction

  // New request gets its ack next cycle
  assign access = bus.stb && !ack_q;
  assign wr_en  = access && bus.we;
  // Falling busy marks the end of a transfer
  assign done   = busy_d && !busy;

  // Current register view and base of a partial write
  always_comb begin
    case (bus.adr)
      spi_pkg::REG_RXTX0:   reg_word = data_q[31:0];
      spi_pkg::REG_RXTX1:   reg_word = data_q[63:32];
      spi_pkg::REG_CTRL: begin
        reg_word = 32'd0;
        reg_word[6:0] = char_len_q;
        reg_word[`CTRL_GO_BSY] = busy;
        reg_word[`CTRL_IE] = ie_q;
      end
      spi_pkg::REG_DIVIDER: reg_word = {16'd0, divider_q};
      spi_pkg::REG_SS:      reg_word = {{(32-`SS_NUM){1'b0}}, ss_q};
      default:              reg_word = 32'd0;
    endcase
  end

  assign wr_word = merge_bytes(reg_word, bus.wdat, bus.sel);
  // GO only while idle
  assign start = wr_en && (bus.adr == spi_pkg::REG_CTRL) &&
                 wr_word[`CTRL_GO_BSY] && !busy;

  assign bus.ack  = ack_q;
  assign bus.rdat = rdat_q;
  assign irq_o    = irq_q;
  // Selects are active low and only during a transfer
  assign spi_ss_o = ~(ss_q & {`SS_NUM{busy}});

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_q      <= 1'b0;
      char_len_q <= 7'd0;
      ie_q       <= 1'b0;
      divider_q  <= 16'd0;
      ss_q       <= '0;
      irq_q      <= 1'b0;
      busy_d     <= 1'b0;
    end else begin
      ack_q  <= access;
      busy_d <= busy;
      // End of transfer wins over the clearing access
      if (done && ie_q) begin
        irq_q <= 1'b1;
      end else if (access) begin
        irq_q <= 1'b0;
      end
      if (wr_en) begin
        case (bus.adr)
          spi_pkg::REG_CTRL: begin
            char_len_q <= wr_word[6:0];
            ie_q       <= wr_word[`CTRL_IE];
          end
          spi_pkg::REG_DIVIDER: divider_q <= wr_word[15:0];
          spi_pkg::REG_SS:      ss_q <= wr_word[`SS_NUM-1:0];
          default: ;
        endcase
      end
    end
  end

  // Received word replaces the shared TX/RX data at the end
  always_ff @(posedge clock) begin
    if (done) begin
      data_q <= rx_data;
    end else if (wr_en && bus.adr == spi_pkg::REG_RXTX0) begin
      data_q[31:0] <= wr_word;
    end else if (wr_en && bus.adr == spi_pkg::REG_RXTX1) begin
      data_q[63:32] <= wr_word;
    end
    if (access) begin
      rdat_q <= reg_word;
    end
  end

  // Length comes from the CTRL word that starts the transfer
  spi_shifter u_spi_shifter (
    .clock      (clock),
    .reset      (reset),
    .start_i    (start),
    .char_len_i (wr_word[6:0]),
    .divider_i  (divider_q),
    .tx_i       (data_q),
    .rx_o       (rx_data),
    .busy_o     (busy),
    .sck_o      (spi_sck_o),
    .mosi_o     (spi_mosi_o),
    .miso_i     (spi_miso_i)
  );
endmodule

`default_nettype wire

// ==== hw/spi_shifter.sv ====
`default_nettype none

module spi_shifter (
  input  wire         clock,
  input  wire         reset,
  input  wire         start_i,
  input  wire  [6:0]  char_len_i,
  input  wire  [15:0] divider_i,
  input  wire  [63:0] tx_i,
  output logic [63:0] rx_o,
  output logic        busy_o,
  output logic        sck_o,
  output logic        mosi_o,
  input  wire         miso_i
);
  logic [63:0] shift_q;
  logic [15:0] clk_cnt_q;
  logic [6:0]  bit_cnt_q;
  logic [6:0]  num_bits;
  logic        busy_q;
  logic        sck_q;
  logic        miso_q;
  logic        tick;
  logic        load;

  // Length 0 and anything past 64 both mean a full 64 bits
  assign num_bits = (char_len_i == 7'd0 || char_len_i > 7'd64) ? 7'd64 : char_len_i;
  assign load     = start_i && !busy_q;
  // Half period elapsed, sck toggles
  assign tick     = busy_q && (clk_cnt_q == 16'd0);

  assign busy_o = busy_q;
  assign sck_o  = sck_q;
  // MSB always sits at the top of the shift register
  assign mosi_o = busy_q && shift_q[63];
  assign rx_o   = shift_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q    <= 1'b0;
      sck_q     <= 1'b0;
      clk_cnt_q <= 16'd0;
      bit_cnt_q <= 7'd0;
    end else if (load) begin
      busy_q    <= 1'b1;
      sck_q     <= 1'b0;
      clk_cnt_q <= divider_i;
      bit_cnt_q <= num_bits;
    end else if (tick) begin
      clk_cnt_q <= divider_i;
      sck_q     <= ~sck_q;
      // Falling edge completes one bit
      if (sck_q) begin
        bit_cnt_q <= bit_cnt_q - 7'd1;
        if (bit_cnt_q == 7'd1) begin
          busy_q <= 1'b0;
        end
      end
    end else if (busy_q) begin
      clk_cnt_q <= clk_cnt_q - 16'd1;
    end
  end

  // Word is left-aligned so that the first bit out is bit 63
  always_ff @(posedge clock) begin
    if (load) begin
      shift_q <= tx_i << (7'd64 - num_bits);
    end else if (tick && sck_q) begin
      // received bits fill in from the bottom, right-aligned at the end
      shift_q <= {shift_q[62:0], miso_q};
    end
    // Sample on the rising edge
    if (tick && !sck_q) begin
      miso_q <= miso_i;
    end
  end
endmodule

`default_nettype wire

// ==== hw/spi_xip_apb.sv ====
`default_nettype none
`include "spi_macros.svh"

module spi_xip_apb (
  input  wire                 clock,
  input  wire                 reset,
  input  wire  [31:0]         paddr_i,
  input  wire                 psel_i,
  input  wire                 penable_i,
  input  wire                 pwrite_i,
  input  wire  [31:0]         pwdata_i,
  input  wire  [3:0]          pstrb_i,
  output logic                pready_o,
  output logic [31:0]         prdata_o,
  output logic                pslverr_o,
  output logic                spi_sck_o,
  output logic [`SS_NUM-1:0]  spi_ss_o,
  output logic                spi_mosi_o,
  input  wire                 spi_miso_i,
  output logic                spi_irq_o
);
  // Handshake between bridge and sequencer
  logic        xip_req;
  logic [23:0] xip_addr;
  logic        xip_done;
  logic [31:0] xip_data;

  // Sequencer to bridge, and bridge to register file
  spi_reg_if seq_bus ();
  spi_reg_if reg_bus ();

  spi_bus_bridge u_spi_bus_bridge (
    .clock      (clock),
    .reset      (reset),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .pstrb_i    (pstrb_i),
    .pready_o   (pready_o),
    .prdata_o   (prdata_o),
    .pslverr_o  (pslverr_o),
    .xip_req_o  (xip_req),
    .xip_addr_o (xip_addr),
    .xip_done_i (xip_done),
    .xip_data_i (xip_data),
    .seq_bus    (seq_bus.slave),
    .reg_bus    (reg_bus.master)
  );

  xip_sequencer u_xip_sequencer (
    .clock      (clock),
    .reset      (reset),
    .xip_req_i  (xip_req),
    .xip_addr_i (xip_addr),
    .xip_done_o (xip_done),
    .xip_data_o (xip_data),
    .bus        (seq_bus.master)
  );

  spi_regs u_spi_regs (
    .clock      (clock),
    .reset      (reset),
    .bus        (reg_bus.slave),
    .spi_sck_o  (spi_sck_o),
    .spi_ss_o   (spi_ss_o),
    .spi_mosi_o (spi_mosi_o),
    .spi_miso_i (spi_miso_i),
    .irq_o      (spi_irq_o)
  );
endmodule

`default_nettype wire

// ==== hw/xip_sequencer.sv ====
`default_nettype none
`include "spi_macros.svh"

module xip_sequencer (
  input  wire         clock,
  input  wire         reset,
  input  wire         xip_req_i,
  input  wire  [23:0] xip_addr_i,
  output logic        xip_done_o,
  output logic [31:0] xip_data_o,
  spi_reg_if.master   bus
);
  spi_pkg::xip_state_e state_q;
  spi_pkg::xip_state_e next_state;
  logic        stb_q;
  logic [23:0] addr_q;
  logic [31:0] data_q;

  // Step order of one flash read
  always_comb begin
    case (state_q)
      spi_pkg::XIP_TX_HI: next_state = spi_pkg::XIP_TX_LO;
      spi_pkg::XIP_TX_LO: next_state = spi_pkg::XIP_DIV;
      spi_pkg::XIP_DIV:   next_state = spi_pkg::XIP_SS;
      spi_pkg::XIP_SS:    next_state = spi_pkg::XIP_GO;
      spi_pkg::XIP_GO:    next_state = spi_pkg::XIP_POLL;
      // Stay until the shifter reports idle
      spi_pkg::XIP_POLL: begin
        if (bus.rdat[`CTRL_GO_BSY]) begin
          next_state = spi_pkg::XIP_POLL;
        end else begin
          next_state = spi_pkg::XIP_READ;
        end
      end
      spi_pkg::XIP_READ:  next_state = spi_pkg::XIP_DONE;
      default:            next_state = spi_pkg::XIP_IDLE;
    endcase
  end

  // Request fields follow the current step
  always_comb begin
    bus.adr  = spi_pkg::REG_CTRL;
    bus.wdat = 32'd0;
    bus.we   = 1'b1;
    case (state_q)
      spi_pkg::XIP_TX_HI: begin
        bus.adr  = spi_pkg::REG_RXTX1;
        bus.wdat = {`FLASH_READ_CMD, addr_q};
      end
      spi_pkg::XIP_TX_LO: bus.adr = spi_pkg::REG_RXTX0;
      spi_pkg::XIP_DIV: begin
        bus.adr  = spi_pkg::REG_DIVIDER;
        bus.wdat = {16'd0, `XIP_DIVIDER};
      end
      spi_pkg::XIP_SS: begin
        bus.adr  = spi_pkg::REG_SS;
        bus.wdat = 32'd1;
      end
      // GO_BSY with length 0, which means 64 bits
      spi_pkg::XIP_GO: bus.wdat = 32'd1 << `CTRL_GO_BSY;
      spi_pkg::XIP_POLL: bus.we = 1'b0;
      spi_pkg::XIP_READ: begin
        bus.adr = spi_pkg::REG_RXTX0;
        bus.we  = 1'b0;
      end
      default: bus.we = 1'b0;
    endcase
  end

  assign bus.sel    = 4'hF;
  assign bus.stb    = stb_q;
  assign xip_done_o = (state_q == spi_pkg::XIP_DONE);
  assign xip_data_o = data_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= spi_pkg::XIP_IDLE;
      stb_q   <= 1'b0;
    end else begin
      case (state_q)
        spi_pkg::XIP_IDLE: begin
          if (xip_req_i) begin
            state_q <= spi_pkg::XIP_TX_HI;
            stb_q   <= 1'b1;
          end
        end
        spi_pkg::XIP_DONE: state_q <= spi_pkg::XIP_IDLE;
        default: begin
          // One idle cycle of strobe between bus cycles
          if (bus.ack) begin
            stb_q   <= 1'b0;
            state_q <= next_state;
          end else begin
            stb_q <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == spi_pkg::XIP_IDLE && xip_req_i) begin
      addr_q <= xip_addr_i;
    end
    if (state_q == spi_pkg::XIP_READ && bus.ack) begin
      data_q <= bus.rdat;
    end
  end
endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/spi_pkg.sv
hw/spi_reg_if.sv
hw/spi_shifter.sv
hw/spi_regs.sv
hw/xip_sequencer.sv
hw/spi_bus_bridge.sv
hw/spi_xip_apb.sv
verification/spi_xip_chk.sv
verification/spi_xip_tb.sv

// ==== verification/spi_xip_chk.sv ====
`default_nettype none
`include "spi_macros.svh"

module spi_xip_chk_m (
  input wire               clock,
  input wire               reset,
  input wire               psel_i,
  input wire               penable_i,
  input wire               pready_i,
  input wire [`SS_NUM-1:0] ss_i,
  input wire               irq_i
);
  // Read back by the testbench at the end
  int fail_count = 0;

  // Ready only answers an access phase
  ready_in_access: assert property (@(posedge clock) disable iff (reset)
    pready_i |-> (psel_i && penable_i))
  else begin
    fail_count++;
    $error("pready_o high outside an APB access phase");
  end

  // Never two slaves selected at once
  one_select: assert property (@(posedge clock) disable iff (reset) $onehot0(~ss_i))
  else begin
    fail_count++;
    $error("more than one slave select low");
  end

  irq_quiet_in_reset: assert property (@(posedge clock) reset |-> !irq_i)
  else begin
    fail_count++;
    $error("spi_irq_o high during reset");
  end
endmodule

bind spi_xip_apb spi_xip_chk_m u_spi_xip_chk (
  .clock     (clock),
  .reset     (reset),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_i  (pready_o),
  .ss_i      (spi_ss_o),
  .irq_i     (spi_irq_o)
);

`default_nettype wire

// ==== verification/spi_xip_stim.txt ====
// op_addr_data_strb per line, op is the ASCII code of W 57, R 52, X 58, E 45, T 54, I 49
// E reads when strb is 0, T takes a flash address, I waits for irq level in data
52_10001010_00000000_0
49_00000000_00000000_0
57_10001014_00001234_f
52_10001014_00001234_0
57_10001014_000000ab_1
52_10001014_000012ab_0
57_10001018_00000001_f
52_10001018_00000001_0
57_10001000_deadbeef_f
57_10001000_00005500_2
52_10001000_dead55ef_0
58_30000000_00010203_0
58_30123456_62636c6d_0
58_30abcdef_223d3c3f_0
58_3ffffffc_03020100_0
52_10001014_00000001_0
57_10001014_00000002_f
54_000100ff_ff010003_0
57_10001004_03004080_f
57_10001000_00000000_f
57_10001010_00001140_f
49_00000000_00000001_0
52_10001000_c0c1c2c3_0
49_00000000_00000000_0
52_10001010_00001040_0
45_20000000_00000000_0
45_10002000_12345678_f
45_30000010_00000000_f
00_00000000_00000000_0

// ==== verification/spi_xip_tb.sv ====
`default_nettype none
`include "spi_macros.svh"

module spi_xip_tb;
  localparam int STIM_MAX = 64;
  localparam int CYCLES_PER_LINE = 200;
  localparam int POLL_MAX = 1000;

  logic               clock;
  logic               reset;
  logic [31:0]        paddr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [31:0]        pwdata;
  logic [3:0]         pstrb;
  logic               pready;
  logic [31:0]        prdata;
  logic               pslverr;
  logic               spi_sck;
  logic [`SS_NUM-1:0] spi_ss;
  logic               spi_mosi;
  logic               spi_irq;

  // Stimulus word holds op letter, address, data and strobe
  logic [75:0] stim_mem [0:STIM_MAX-1];
  int          stim_count;
  bit          stim_loaded = 1'b0;
  int          errors = 0;
  int          checks = 0;

  // Flash model state
  logic        flash_miso = 1'b0;
  logic [31:0] flash_cmd = 32'd0;
  int          flash_bits = 0;
  logic        sck_d = 1'b0;

  spi_xip_apb u_spi_xip_apb (
    .clock      (clock),
    .reset      (reset),
    .paddr_i    (paddr),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .pwdata_i   (pwdata),
    .pstrb_i    (pstrb),
    .pready_o   (pready),
    .prdata_o   (prdata),
    .pslverr_o  (pslverr),
    .spi_sck_o  (spi_sck),
    .spi_ss_o   (spi_ss),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (flash_miso),
    .spi_irq_o  (spi_irq)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Data bit idx after the address phase
  // Byte a is a[7:0] ^ a[15:8]
  function automatic logic flash_bit(input logic [23:0] base, input int idx);
    logic [23:0] addr;
    logic [7:0]  data;
    addr = base + 24'(idx / 8);
    data = addr[7:0] ^ addr[15:8];
    return data[3'(7 - idx % 8)];
  endfunction

  // Flash on select 0 sampled between clock edges
  always @(negedge clock) begin
    if (spi_ss[0]) begin
      flash_bits <= 0;
      flash_miso <= 1'b0;
    end else if (spi_sck && !sck_d) begin
      // Opcode and address come in on rising sck
      if (flash_bits < 32) begin
        flash_cmd <= {flash_cmd[30:0], spi_mosi};
      end
      flash_bits <= flash_bits + 1;
    end else if (!spi_sck && sck_d && flash_bits >= 32 &&
                 flash_cmd[31:24] == `FLASH_READ_CMD) begin
      flash_miso <= flash_bit(flash_cmd[23:0], flash_bits - 32);
    end
    sck_d <= spi_sck;
  end

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s: got %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  // One APB transfer entered and left just after a rising edge
  task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, output logic [31:0] rdata,
                          output logic err);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    pstrb   = strb;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clock);
    #5;
    penable = 1'b1;
    @(negedge clock);
    while (pready !== 1'b1) begin
      @(negedge clock);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    #5;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic idle_gap();
    repeat ($urandom % 4) begin
      @(posedge clock);
      #5;
    end
  endtask

  // Flash read done by hand through TX1, CTRL and polling
  task automatic software_transfer(input logic [23:0] flash_addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    int          polls;
    apb_xfer(1'b1, `SPI_BASE + 32'h04, {`FLASH_READ_CMD, flash_addr}, 4'hF, rdata, err);
    apb_xfer(1'b1, `SPI_BASE, 32'd0, 4'hF, rdata, err);
    // GO_BSY with a 64-bit character
    apb_xfer(1'b1, `SPI_BASE + 32'h10, 32'h0000_0140, 4'hF, rdata, err);
    polls = 0;
    rdata = 32'h0000_0100;
    while (rdata[`CTRL_GO_BSY] && polls < POLL_MAX) begin
      apb_xfer(1'b0, `SPI_BASE + 32'h10, 32'd0, 4'h0, rdata, err);
      polls++;
    end
    if (rdata[`CTRL_GO_BSY]) begin
      errors++;
      $display("GO_BSY never cleared during the software transfer");
    end
    apb_xfer(1'b0, `SPI_BASE, 32'd0, 4'h0, rdata, err);
    check_word("software transfer RX0", rdata, exp);
  endtask

  // Irq may take a whole transfer to rise
  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (spi_irq !== level && n < 2 * POLL_MAX) begin
      @(posedge clock);
      #5;
      n++;
    end
    checks++;
    if (spi_irq !== level) begin
      errors++;
      $display("Interrupt line never reached level %0b at t=%0t", level, $time);
    end
  endtask

  initial begin
    int          i;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] rdata;
    logic        err;
    void'($urandom(32'h7b23d6d8));
    reset   = 1'b1;
    paddr   = 32'd0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = 32'd0;
    pstrb   = 4'h0;
    $readmemh("verification/spi_xip_stim.txt", stim_mem);
    // Op 00 closes the list
    stim_count = 0;
    while (stim_count < STIM_MAX && stim_mem[stim_count][75:68] !== 8'h00) begin
      stim_count++;
    end
    if (stim_count == STIM_MAX) begin
      errors++;
      $display("Stimulus file has no end line");
      stim_count = 0;
    end
    stim_loaded = 1'b1;
    repeat (10) @(posedge clock);
    #5;
    reset = 1'b0;
    checks++;
    if (spi_ss !== '1) begin
      errors++;
      $display("[FAIL] t=%0t slave selects not all high after reset", $time);
    end
    for (i = 0; i < stim_count; i++) begin
      op   = stim_mem[i][75:68];
      addr = stim_mem[i][67:36];
      data = stim_mem[i][35:4];
      strb = stim_mem[i][3:0];
      case (op)
        "W": begin
          apb_xfer(1'b1, addr, data, strb, rdata, err);
          check_word("write pslverr", {31'd0, err}, 32'd0);
        end
        "R", "X": begin
          apb_xfer(1'b0, addr, 32'd0, 4'h0, rdata, err);
          check_word("read pslverr", {31'd0, err}, 32'd0);
          check_word(op == "X" ? "flash read data" : "register read data", rdata, data);
        end
        // Strobe zero makes it a read
        "E": begin
          apb_xfer(strb != 4'h0, addr, data, strb, rdata, err);
          check_word("error response pslverr", {31'd0, err}, 32'd1);
        end
        "T": software_transfer(addr[23:0], data);
        "I": wait_irq(data[0]);
        default: begin
          errors++;
          $display("Unknown stimulus operation %02h on entry %0d", op, i);
        end
      endcase
      idle_gap();
    end
    errors += u_spi_xip_apb.u_spi_xip_chk.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             u_spi_xip_apb.u_spi_xip_chk.fail_count);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Budget grows with the stimulus length
  initial begin
    wait (stim_loaded);
    repeat (stim_count * CYCLES_PER_LINE + 20) @(posedge clock);
    $display("Watchdog expired before the stimulus finished");
    $display("SIMULATION FAILED");
    $finish;
  end
endmodule

`default_nettype wire
